// File: verilog/id_pkg.sv
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // opcodes and the one funct code we decode
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_J       = 6'h02;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;
    } j_fields_t;

    // one instruction word, three views
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
        j_fields_t j_fields;
    } inst_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_t           inst;
    } queue_entry_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;    // pc of inst0, inst1 sits at pc+4
        inst_t           inst0;
        inst_t           inst1;
    } fetch_pair_t;

    // register write in flight
    typedef struct packed {
        logic                  we;
        logic                  is_load;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } rf_write_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_t           inst;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
    } issue_slot_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_t;

endpackage

// File: verilog/inst_queue.sv
`timescale 1ns/1ns

module inst_queue import id_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  fetch_pair_t  push_i,
    input  logic [1:0]   pop_cnt_i,
    input  logic         flush_i,
    output queue_entry_t head0_o,
    output queue_entry_t head1_o,
    output logic         head0_valid_o,
    output logic         head1_valid_o,
    output logic         full_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    queue_entry_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;

    // circular pointer advance, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_add(logic [PTR_W-1:0] ptr, logic [1:0] n);
        logic [PTR_W+1:0] sum;
        sum = (PTR_W+2)'(ptr) + (PTR_W+2)'(n);
        if (sum >= (PTR_W+2)'(QUEUE_DEPTH)) begin
            sum = sum - (PTR_W+2)'(QUEUE_DEPTH);
        end
        return sum[PTR_W-1:0];
    endfunction

    assign push_ok       = push_i.valid & ~full_o & ~flush_i;  // flush drops the push
    assign full_o        = count > CNT_W'(QUEUE_DEPTH - 2);    // room for less than a pair
    assign head0_valid_o = count != '0;
    assign head1_valid_o = count > CNT_W'(1);
    assign head0_o       = mem[rd_ptr];
    assign head1_o       = mem[ptr_add(rd_ptr, 2'd1)];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= ptr_add(rd_ptr, pop_cnt_i);
            if (push_ok) begin
                wr_ptr <= ptr_add(wr_ptr, 2'd2);
            end
            count <= count + (push_ok ? CNT_W'(2) : CNT_W'(0)) - CNT_W'(pop_cnt_i);
        end
    end

    // both words of the pair in one edge
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr]                <= '{pc: push_i.pc, inst: push_i.inst0};
            mem[ptr_add(wr_ptr, 2'd1)] <= '{pc: push_i.pc + XLEN'(4), inst: push_i.inst1};
        end
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file import id_pkg::*; (
    input  logic                       clk,
    input  rf_write_t                  wr_i,
    input  logic [3:0][REG_ADDR_W-1:0] raddr_i,
    output logic [3:0][XLEN-1:0]       rdata_o
);

    logic [XLEN-1:0] regs [1:31];  // r0 has no storage

    always_ff @(posedge clk) begin
        if (wr_i.we && wr_i.waddr != '0) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // no write-through here, the forwarding units cover it
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
        end
    end

endmodule

// File: verilog/operand_fwd.sv
`timescale 1ns/1ns

module operand_fwd import id_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs_i,
    input  logic [REG_ADDR_W-1:0] rt_i,
    input  logic [XLEN-1:0]       rf_rs_i,
    input  logic [XLEN-1:0]       rf_rt_i,
    input  rf_write_t             ex_wr_i,
    input  rf_write_t             wb_wr_i,
    output logic [XLEN-1:0]       src_a_o,
    output logic [XLEN-1:0]       src_b_o
);

    // write in flight to a nonzero register we read
    function automatic logic hit(rf_write_t wr, logic [REG_ADDR_W-1:0] addr);
        return wr.we && (wr.waddr != '0) && (wr.waddr == addr);
    endfunction

    // execute is younger than writeback, so it wins
    assign src_a_o = hit(ex_wr_i, rs_i) ? ex_wr_i.wdata :
                     hit(wb_wr_i, rs_i) ? wb_wr_i.wdata : rf_rs_i;

    assign src_b_o = hit(ex_wr_i, rt_i) ? ex_wr_i.wdata :
                     hit(wb_wr_i, rt_i) ? wb_wr_i.wdata : rf_rt_i;

endmodule

// File: verilog/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl import id_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall_i,
    input  queue_entry_t                head0_i,
    input  queue_entry_t                head1_i,
    input  logic                        head0_valid_i,
    input  logic                        head1_valid_i,
    input  rf_write_t                   ex_wr_i,
    input  logic [1:0][1:0][XLEN-1:0]   ops_i,     // [slot][0] src_a, [slot][1] src_b
    output logic [1:0][REG_ADDR_W-1:0]  rs_o,
    output logic [1:0][REG_ADDR_W-1:0]  rt_o,
    output logic [1:0]                  pop_cnt_o,
    output logic                        flush_o,
    output issue_slot_t [1:0]           issue_o,
    output branch_t                     br_o
);

    queue_entry_t [1:0]         head;
    logic [1:0]                 head_valid;
    logic [1:0]                 is_addu, is_addiu, is_lw, is_beq, is_bne, is_j, is_br;
    logic [1:0]                 load_use, issue;
    logic                       wr_en;
    logic [REG_ADDR_W-1:0]      wr_addr;
    logic                       dep, fire, br_taken;
    logic [XLEN-1:0]            imm_ext, br_target;
    issue_slot_t [1:0]          slot_d, slot_q;
    logic                       taken_q;
    logic [XLEN-1:0]            target_q;

    assign head       = {head1_i, head0_i};
    assign head_valid = {head1_valid_i, head0_valid_i};

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            is_addu[k]  = (head[k].inst.r_fields.op == OP_SPECIAL) &&
                          (head[k].inst.r_fields.funct == FN_ADDU);
            is_addiu[k] = head[k].inst.i_fields.op == OP_ADDIU;
            is_lw[k]    = head[k].inst.i_fields.op == OP_LW;
            is_beq[k]   = head[k].inst.i_fields.op == OP_BEQ;
            is_bne[k]   = head[k].inst.i_fields.op == OP_BNE;
            is_j[k]     = head[k].inst.j_fields.op == OP_J;
            is_br[k]    = is_beq[k] | is_bne[k] | is_j[k];
            // unread sources go out as r0
            rs_o[k] = (is_addu[k] | is_addiu[k] | is_lw[k] | is_beq[k] | is_bne[k]) ?
                      head[k].inst.r_fields.rs : '0;
            rt_o[k] = (is_addu[k] | is_beq[k] | is_bne[k]) ? head[k].inst.r_fields.rt : '0;
            load_use[k] = ex_wr_i.we && ex_wr_i.is_load && (ex_wr_i.waddr != '0) &&
                          ((rs_o[k] == ex_wr_i.waddr) || (rt_o[k] == ex_wr_i.waddr));
        end
    end

    // destination written by slot 0
    assign wr_en   = is_addu[0] | is_addiu[0] | is_lw[0];
    assign wr_addr = is_addu[0] ? head[0].inst.r_fields.rd : head[0].inst.i_fields.rt;

    // slot 1 reads what slot 0 writes
    assign dep = wr_en && (wr_addr != '0) &&
                 ((rs_o[1] == wr_addr) || (rt_o[1] == wr_addr));

    // a branch waits for its delay slot
    assign issue[0] = head_valid[0] & ~load_use[0] &
                      (~is_br[0] | (head_valid[1] & ~load_use[1]));
    assign issue[1] = issue[0] & head_valid[1] & ~load_use[1] &
                      (is_br[0] | (~is_br[1] & ~dep & ~(is_lw[0] & is_lw[1])));

    assign fire      = ~stall_i;
    assign pop_cnt_o = fire ? ({1'b0, issue[0]} + {1'b0, issue[1]}) : 2'd0;

    assign imm_ext   = {{(XLEN-18){head[0].inst.i_fields.imm[15]}},
                        head[0].inst.i_fields.imm, 2'b00};
    assign br_taken  = issue[0] & (is_j[0] |
                       (is_beq[0] & (ops_i[0][0] == ops_i[0][1])) |
                       (is_bne[0] & (ops_i[0][0] != ops_i[0][1])));
    assign br_target = is_j[0] ?
                       {head[0].pc[XLEN-1:XLEN-4], head[0].inst.j_fields.index, 2'b00} :
                       head[0].pc + XLEN'(4) + imm_ext;
    assign flush_o   = fire & br_taken;  // delay slot leaves, the rest is dropped

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            slot_d[k] = '{valid: issue[k], pc: head[k].pc, inst: head[k].inst,
                          src_a: ops_i[k][0], src_b: ops_i[k][1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_q[0].valid <= 1'b0;
            slot_q[1].valid <= 1'b0;
            taken_q         <= 1'b0;
        end else if (fire) begin
            slot_q   <= slot_d;
            taken_q  <= br_taken;
            target_q <= br_target;
        end
    end

    assign issue_o = slot_q;
    assign br_o    = '{taken: taken_q, target: target_q};

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/1ns

module id_stage import id_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pair_t       fetch_i,
    output logic              fetch_full_o,
    input  rf_write_t         ex_wr_i,
    input  rf_write_t         wb_wr_i,
    input  logic              stall_i,
    output issue_slot_t [1:0] issue_o,
    output branch_t           br_o
);

    queue_entry_t               head0, head1;
    logic                       head0_valid, head1_valid;
    logic [1:0]                 pop_cnt;
    logic                       flush;
    logic [1:0][REG_ADDR_W-1:0] rs, rt;
    logic [3:0][XLEN-1:0]       rf_rdata;   // rs0, rt0, rs1, rt1
    wire  [1:0][1:0][XLEN-1:0]  ops;

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk           (clk),
        .rst           (rst),
        .push_i        (fetch_i),
        .pop_cnt_i     (pop_cnt),
        .flush_i       (flush),
        .head0_o       (head0),
        .head1_o       (head1),
        .head0_valid_o (head0_valid),
        .head1_valid_o (head1_valid),
        .full_o        (fetch_full_o)
    );

    issue_ctrl u_issue (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .head0_i       (head0),
        .head1_i       (head1),
        .head0_valid_i (head0_valid),
        .head1_valid_i (head1_valid),
        .ex_wr_i       (ex_wr_i),
        .ops_i         (ops),
        .rs_o          (rs),
        .rt_o          (rt),
        .pop_cnt_o     (pop_cnt),
        .flush_o       (flush),
        .issue_o       (issue_o),
        .br_o          (br_o)
    );

    reg_file u_rf (
        .clk     (clk),
        .wr_i    (wb_wr_i),
        .raddr_i ({rt[1], rs[1], rt[0], rs[0]}),
        .rdata_o (rf_rdata)
    );

    operand_fwd u_fwd0 (
        .rs_i    (rs[0]),
        .rt_i    (rt[0]),
        .rf_rs_i (rf_rdata[0]),
        .rf_rt_i (rf_rdata[1]),
        .ex_wr_i (ex_wr_i),
        .wb_wr_i (wb_wr_i),
        .src_a_o (ops[0][0]),
        .src_b_o (ops[0][1])
    );

    operand_fwd u_fwd1 (
        .rs_i    (rs[1]),
        .rt_i    (rt[1]),
        .rf_rs_i (rf_rdata[2]),
        .rf_rt_i (rf_rdata[3]),
        .ex_wr_i (ex_wr_i),
        .wb_wr_i (wb_wr_i),
        .src_a_o (ops[1][0]),
        .src_b_o (ops[1][1])
    );

endmodule

// File: testbench/id_stage_props.sv
`timescale 1ns/1ns

module id_stage_props import id_pkg::*; (
    input logic              clk,
    input logic              rst,
    input fetch_pair_t       fetch_i,
    input logic              fetch_full_o,
    input issue_slot_t [1:0] issue_o,
    input branch_t           br_o
);

    // producer must respect the full level
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        fetch_i.valid |-> !fetch_full_o)
        else $error("push while queue full");

    a_slot_order: assert property (@(posedge clk) disable iff (rst)
        issue_o[1].valid |-> issue_o[0].valid)
        else $error("slot 1 valid without slot 0");

    a_branch_issue: assert property (@(posedge clk) disable iff (rst)
        br_o.taken |-> issue_o[0].valid)
        else $error("branch taken without an issue");

    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !issue_o[0].valid && !issue_o[1].valid && !br_o.taken)
        else $error("outputs active right after reset");

endmodule

bind id_stage id_stage_props u_props (.*);

// File: testbench/id_stage_tb.sv
`timescale 1ns/1ns

module id_stage_tb import id_pkg::*; ();

    typedef struct {
        logic [31:0] pc;
        logic [31:0] w0;
        logic [31:0] w1;
        int          npair;   // instructions in the first issue of the row
        logic        taken;
    } row_t;

    localparam int NROWS = 7;

    logic              clk = 1'b0;
    logic              rst;
    fetch_pair_t       fetch_i;
    logic              fetch_full_o;
    rf_write_t         ex_wr_i;
    rf_write_t         wb_wr_i;
    logic              stall_i;
    issue_slot_t [1:0] issue_o;
    branch_t           br_o;

    row_t              tbl [NROWS];
    logic [31:0]       rf_model [32];
    logic [31:0]       exp_pc [$];
    logic [31:0]       exp_w [$];
    issue_slot_t [1:0] snap;
    int                errors = 0;
    int                idx;

    id_stage #(.QUEUE_DEPTH(8)) u_dut (.*);

    always #10 clk = ~clk;

    // architectural register state, written by writeback
    always @(posedge clk) begin
        if (wb_wr_i.we && wb_wr_i.waddr != 5'd0) begin
            rf_model[wb_wr_i.waddr] <= wb_wr_i.wdata;
        end
    end

    initial begin
        #((NROWS * 40 + 8) * 20);
        $display("watchdog timeout, the test sequence did not complete");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic is_addu(logic [31:0] w);
        return w[31:26] == OP_SPECIAL && w[5:0] == FN_ADDU;
    endfunction

    function automatic logic reads_rs(logic [31:0] w);
        return is_addu(w) || w[31:26] inside {OP_ADDIU, OP_LW, OP_BEQ, OP_BNE};
    endfunction

    function automatic logic reads_rt(logic [31:0] w);
        return is_addu(w) || w[31:26] inside {OP_BEQ, OP_BNE};
    endfunction

    function automatic logic [4:0] dest(logic [31:0] w);
        if (is_addu(w)) return w[15:11];
        if (w[31:26] inside {OP_ADDIU, OP_LW}) return w[20:16];
        return 5'd0;
    endfunction

    // pairing rule for two adjacent non-branch-led instructions
    function automatic logic pair_ok(logic [31:0] a, logic [31:0] b);
        logic [4:0] d;
        d = dest(a);
        if (b[31:26] inside {OP_BEQ, OP_BNE, OP_J}) return 1'b0;
        if (d != 5'd0 && ((reads_rs(b) && b[25:21] == d) || (reads_rt(b) && b[20:16] == d)))
            return 1'b0;
        return !(a[31:26] == OP_LW && b[31:26] == OP_LW);
    endfunction

    function automatic logic [31:0] fwd(logic [4:0] r);
        if (r == 5'd0) return 32'd0;
        if (ex_wr_i.we && ex_wr_i.waddr == r) return ex_wr_i.wdata;
        if (wb_wr_i.we && wb_wr_i.waddr == r) return wb_wr_i.wdata;
        return rf_model[r];
    endfunction

    function automatic logic [31:0] br_target(logic [31:0] pc, logic [31:0] w);
        if (w[31:26] == OP_J) return {pc[31:28], w[25:0], 2'b00};
        return pc + 32'd4 + {{14{w[15]}}, w[15:0], 2'b00};
    endfunction

    task automatic abort_run(string msg);
        errors++;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_slot(int k, logic [31:0] pc, logic [31:0] w);
        assert (issue_o[k].valid === 1'b1)
        else abort_run($sformatf("issue slot %0d not valid when an issue was expected", k));
        check_val($sformatf("issue_o[%0d].pc", k), issue_o[k].pc, pc);
        check_val($sformatf("issue_o[%0d].inst", k), issue_o[k].inst, w);
        check_val($sformatf("issue_o[%0d].src_a", k), issue_o[k].src_a,
                  reads_rs(w) ? fwd(w[25:21]) : 32'd0);
        check_val($sformatf("issue_o[%0d].src_b", k), issue_o[k].src_b,
                  reads_rt(w) ? fwd(w[20:16]) : 32'd0);
    endtask

    task automatic check_alone();
        check_val("issue_o[1].valid", {31'd0, issue_o[1].valid}, 32'd0);
    endtask

    task automatic check_branch(logic taken, logic [31:0] pc, logic [31:0] w);
        check_val("br_o.taken", {31'd0, br_o.taken}, {31'd0, taken});
        if (taken) check_val("br_o.target", br_o.target, br_target(pc, w));
    endtask

    task automatic push_pair(logic [31:0] pc, logic [31:0] w0, logic [31:0] w1);
        @(posedge clk);
        fetch_i <= '{valid: 1'b1, pc: pc, inst0: w0, inst1: w1};
        @(posedge clk);
        fetch_i.valid <= 1'b0;
    endtask

    task automatic wait_issue();
        for (int c = 0; c < 20; c++) begin
            @(posedge clk);
            #1;
            if (issue_o[0].valid) return;
        end
        abort_run("no instruction issued within 20 cycles");
    endtask

    task automatic expect_quiet(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            assert (issue_o[0].valid === 1'b0)
            else abort_run("an instruction issued while it had to be held or dropped");
        end
    endtask

    task automatic run_row(row_t r);
        push_pair(r.pc, r.w0, r.w1);
        wait_issue();
        check_slot(0, r.pc, r.w0);
        if (r.npair == 2) begin
            check_slot(1, r.pc + 32'd4, r.w1);
            check_branch(r.taken, r.pc, r.w0);
        end else begin
            check_alone();
            check_branch(1'b0, r.pc, r.w0);
            wait_issue();
            check_slot(0, r.pc + 32'd4, r.w1);
            check_alone();
        end
    endtask

    initial begin
        void'($urandom(52566));
        rst     = 1'b1;
        fetch_i = '0;
        ex_wr_i = '0;
        wb_wr_i = '0;
        stall_i = 1'b0;
        foreach (rf_model[i]) rf_model[i] = 32'd0;

        tbl[0] = '{32'h1000, enc_r(1, 2, 3), enc_i(OP_ADDIU, 5, 4, 16'd7), 2, 1'b0};
        tbl[1] = '{32'h1010, enc_r(1, 2, 6), enc_r(6, 3, 7), 1, 1'b0};           // dependent
        tbl[2] = '{32'h1020, enc_i(OP_LW, 1, 8, 16'd0), enc_i(OP_LW, 2, 9, 16'd4), 1, 1'b0};
        tbl[3] = '{32'h1030, enc_r(1, 2, 0), enc_r(0, 0, 10), 2, 1'b0};          // r0 is no dep
        tbl[4] = '{32'h1040, enc_i(OP_BEQ, 1, 1, 16'hfff0), enc_r(2, 3, 11), 2, 1'b1};
        tbl[5] = '{32'h1050, enc_i(OP_BNE, 1, 1, 16'd4), 32'd0, 2, 1'b0};
        tbl[6] = '{32'h1060, {OP_J, 26'h100}, enc_i(OP_ADDIU, 0, 12, 16'd1), 2, 1'b1};

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // preload r1..r31 through writeback
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            wb_wr_i <= '{we: 1'b1, is_load: 1'b0, waddr: 5'(r), wdata: $urandom};
        end
        @(posedge clk);
        wb_wr_i <= '0;

        for (int i = 0; i < NROWS; i++) run_row(tbl[i]);

        // held execute and writeback results, ex wins on r1
        @(posedge clk);
        ex_wr_i <= '{we: 1'b1, is_load: 1'b0, waddr: 5'd1, wdata: 32'hcafe_0001};
        wb_wr_i <= '{we: 1'b1, is_load: 1'b0, waddr: 5'd1, wdata: 32'hbeef_0002};
        for (int i = 0; i < NROWS; i++) run_row(tbl[i]);
        @(posedge clk);
        wb_wr_i <= '{we: 1'b1, is_load: 1'b0, waddr: 5'd2, wdata: 32'h1234_5678};
        run_row(tbl[0]);
        // writes in flight to r0 never reach a reader of r0
        @(posedge clk);
        ex_wr_i <= '{we: 1'b1, is_load: 1'b0, waddr: 5'd0, wdata: 32'hdead_0003};
        wb_wr_i <= '{we: 1'b1, is_load: 1'b0, waddr: 5'd0, wdata: 32'hdead_0004};
        run_row(tbl[3]);
        @(posedge clk);
        ex_wr_i <= '0;
        wb_wr_i <= '0;

        // load-use hold on r1
        @(posedge clk);
        ex_wr_i <= '{we: 1'b1, is_load: 1'b1, waddr: 5'd1, wdata: 32'h0bad_0bad};
        push_pair(tbl[0].pc, tbl[0].w0, tbl[0].w1);
        expect_quiet(5);
        @(posedge clk);
        ex_wr_i <= '0;
        wait_issue();
        check_slot(0, tbl[0].pc, tbl[0].w0);
        check_slot(1, tbl[0].pc + 32'd4, tbl[0].w1);

        // load on r5 only hits slot 1, so slot 0 goes alone
        @(posedge clk);
        ex_wr_i <= '{we: 1'b1, is_load: 1'b1, waddr: 5'd5, wdata: 32'h0bad_0bad};
        push_pair(tbl[0].pc, tbl[0].w0, tbl[0].w1);
        wait_issue();
        check_slot(0, tbl[0].pc, tbl[0].w0);
        check_alone();
        expect_quiet(3);
        @(posedge clk);
        ex_wr_i <= '0;
        wait_issue();
        check_slot(0, tbl[0].pc + 32'd4, tbl[0].w1);
        check_alone();

        // taken branch flushes the pair queued behind it
        @(posedge clk);
        stall_i <= 1'b1;
        push_pair(tbl[4].pc, tbl[4].w0, tbl[4].w1);
        push_pair(tbl[1].pc, tbl[1].w0, tbl[1].w1);
        @(posedge clk);
        stall_i <= 1'b0;
        wait_issue();
        check_slot(0, tbl[4].pc, tbl[4].w0);
        check_slot(1, tbl[4].pc + 32'd4, tbl[4].w1);
        check_branch(1'b1, tbl[4].pc, tbl[4].w0);
        expect_quiet(4);
        run_row('{br_target(tbl[4].pc, tbl[4].w0), tbl[0].w0, tbl[0].w1, 2, 1'b0});

        // fill under stall until full, then drain in order
        @(posedge clk);
        stall_i <= 1'b1;
        @(posedge clk);
        #1 snap = issue_o;
        for (int i = 0; i < 4 && !fetch_full_o; i++) begin
            push_pair(tbl[i].pc, tbl[i].w0, tbl[i].w1);
            exp_pc.push_back(tbl[i].pc);
            exp_w.push_back(tbl[i].w0);
            exp_pc.push_back(tbl[i].pc + 32'd4);
            exp_w.push_back(tbl[i].w1);
            #1;
        end
        check_val("fetch_full_o", {31'd0, fetch_full_o}, 32'd1);
        assert (issue_o === snap)
        else abort_run("issue_o changed while stall_i was held");
        @(posedge clk);
        stall_i <= 1'b0;
        idx = 0;
        while (idx < exp_w.size()) begin
            wait_issue();
            check_slot(0, exp_pc[idx], exp_w[idx]);
            if (idx + 1 < exp_w.size() && pair_ok(exp_w[idx], exp_w[idx + 1])) begin
                check_slot(1, exp_pc[idx + 1], exp_w[idx + 1]);
                idx += 2;
            end else begin
                check_alone();
                idx += 1;
            end
        end
        check_val("fetch_full_o", {31'd0, fetch_full_o}, 32'd0);

        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/id_pkg.sv
verilog/inst_queue.sv
verilog/reg_file.sv
verilog/operand_fwd.sv
verilog/issue_ctrl.sv
verilog/id_stage.sv
testbench/id_stage_props.sv
testbench/id_stage_tb.sv

// File: Makefile
TOP = id_stage_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

obj_dir/V$(TOP): filelist.f verilog/*.sv testbench/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
